//--- all.f
design/rp_bus_pkg.sv
design/rp_adc_pkg.sv
design/adc_sample_conv.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/ams_pdm.sv
design/exp_trig_route.sv
design/rp_frontend_top.sv
dv/tb_rp_frontend.sv

//--- design/adc_sample_conv.sv
////////////////////////////////////////
// ADC raw word to two's complement, 2 stages
////////////////////////////////////////

`timescale 1ns/1ps

module adc_sample_conv (
  input  logic                                          adc_clk_01,
  input  logic                                          rst_n_i,
  input  rp_adc_pkg::adc_raw_t    [rp_adc_pkg::ADC_CHN-1:0] raw_i,
  output rp_adc_pkg::adc_sample_t [rp_adc_pkg::ADC_CHN-1:0] sample_o
);

  localparam int unsigned MSB = rp_adc_pkg::ADC_BITS - 1;

  rp_adc_pkg::adc_sample_t [rp_adc_pkg::ADC_CHN-1:0] conv_q;  // stage 1
  rp_adc_pkg::adc_sample_t [rp_adc_pkg::ADC_CHN-1:0] out_q;   // stage 2

  ////////////////////////////////////////
  // conversion pipeline
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      conv_q <= '0;
      out_q  <= '0;
    end else begin
      for (int ch = 0; ch < rp_adc_pkg::ADC_CHN; ch++) begin
        // keep msb, flip the rest
        conv_q[ch] <= {raw_i[ch][MSB], ~raw_i[ch][MSB-1:0]};
      end
      out_q <= conv_q;  // second level, retiming only
    end
  end

  assign sample_o = out_q;

endmodule : adc_sample_conv

//--- design/ams_pdm.sv
////////////////////////////////////////
// slow DAC config regs and 4 PDM modulators
////////////////////////////////////////

`timescale 1ns/1ps

module ams_pdm (
  input  logic                 adc_clk_01,
  input  logic                 rst_n_i,
  input  rp_bus_pkg::sys_req_t req_i,
  output rp_bus_pkg::sys_rsp_t rsp_o,
  output logic [4-1:0]         dac_pdm_o
);

  localparam int unsigned PB = rp_adc_pkg::PDM_BITS;

  logic [rp_bus_pkg::OFS_BITS-1:0]  ofs;
  logic                             strobe;
  logic [31:0]                      rd_dat;
  logic                             rd_hit;
  rp_adc_pkg::pdm_cfg_t [4-1:0]     cfg_q;    // one level per channel
  logic [4-1:0][PB-1:0]             acc_q;    // wraps at 255
  logic [4-1:0]                     pdm_q;    // registered carry
  logic                             ack_q, err_q;
  logic [31:0]                      rdata_q;

  assign ofs    = req_i.addr[rp_bus_pkg::OFS_BITS-1:0];
  assign strobe = req_i.wen | req_i.ren;

  ////////////////////////////////////////
  // register access
  ////////////////////////////////////////

  always_comb begin
    rd_dat = '0;
    rd_hit = 1'b1;
    case (ofs)
      rp_bus_pkg::AMS_DAC_A: rd_dat = 32'(cfg_q[0]);
      rp_bus_pkg::AMS_DAC_B: rd_dat = 32'(cfg_q[1]);
      rp_bus_pkg::AMS_DAC_C: rd_dat = 32'(cfg_q[2]);
      rp_bus_pkg::AMS_DAC_D: rd_dat = 32'(cfg_q[3]);
      default:               rd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= strobe;
      err_q <= strobe & ~rd_hit;  // unknown offset
      if (req_i.wen) begin
        case (ofs)
          rp_bus_pkg::AMS_DAC_A: cfg_q[0] <= req_i.wdata[PB-1:0];
          rp_bus_pkg::AMS_DAC_B: cfg_q[1] <= req_i.wdata[PB-1:0];
          rp_bus_pkg::AMS_DAC_C: cfg_q[2] <= req_i.wdata[PB-1:0];
          rp_bus_pkg::AMS_DAC_D: cfg_q[3] <= req_i.wdata[PB-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk_01) begin
    if (strobe) rdata_q <= req_i.ren ? rd_dat : '0;
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

  ////////////////////////////////////////
  // PDM, first order sigma delta
  ////////////////////////////////////////

  // carry out density is cfg/256
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
      pdm_q <= '0;
    end else begin
      for (int ch = 0; ch < 4; ch++) begin
        {pdm_q[ch], acc_q[ch]} <= {1'b0, acc_q[ch]} + {1'b0, cfg_q[ch]};
      end
    end
  end

  assign dac_pdm_o = pdm_q;

endmodule : ams_pdm

//--- design/exp_trig_route.sv
////////////////////////////////////////
// trigger out on exp_n[0], ext trigger mask
////////////////////////////////////////

`timescale 1ns/1ps

module exp_trig_route (
  input  rp_adc_pkg::daisy_mode_t             daisy_mode_i,
  input  rp_adc_pkg::exp_pins_t               exp_n_reg_i,
  input  logic                                scope_trig_i,
  input  logic                                asg_trig_i,
  input  logic [rp_adc_pkg::DAISY_W-1:0]      daisy_rx_dat_i,
  input  logic                                exp_p_in0_i,
  output rp_adc_pkg::exp_pins_t               exp_n_o,
  output logic                                trig_ext_o
);

  logic trig_sel;    // trigger chosen for output
  logic daisy_trig;  // any activity on daisy rx

  assign trig_sel   = daisy_mode_i.trig_sel_asg ? asg_trig_i : scope_trig_i;
  assign daisy_trig = |daisy_rx_dat_i;

  always_comb begin
    exp_n_o        = exp_n_reg_i;  // register value for all other pins
    exp_n_o.dat[0] = exp_n_reg_i.dat[0] | (daisy_mode_i.trig_out_en & trig_sel);
    exp_n_o.oe[0]  = exp_n_reg_i.oe[0]  | daisy_mode_i.trig_out_en;  // force drive
  end

  // ext trig blocked while daisy link carries trigger
  assign trig_ext_o = exp_p_in0_i & ~(daisy_mode_i.sync_en & daisy_trig);

endmodule : exp_trig_route

//--- design/hk_regs.sv
////////////////////////////////////////
// housekeeping regs: id, daisy mode, expansion
////////////////////////////////////////

`timescale 1ns/1ps

module hk_regs (
  input  logic                                 adc_clk_01,
  input  logic                                 rst_n_i,
  input  rp_bus_pkg::sys_req_t                 req_i,
  output rp_bus_pkg::sys_rsp_t                 rsp_o,
  input  logic [rp_adc_pkg::EXP_W-1:0]         exp_p_in_i,
  input  logic [rp_adc_pkg::EXP_W-1:0]         exp_n_in_i,
  output rp_adc_pkg::daisy_mode_t              daisy_mode_o,
  output rp_adc_pkg::exp_pins_t                exp_p_o,
  output rp_adc_pkg::exp_pins_t                exp_n_o
);

  localparam int unsigned EW = rp_adc_pkg::EXP_W;
  localparam int unsigned DW = $bits(rp_adc_pkg::daisy_mode_t);

  logic [rp_bus_pkg::OFS_BITS-1:0] ofs;
  logic                            strobe;
  logic [31:0]                     rd_dat;   // read mux
  logic                            rd_hit;   // known offset
  rp_adc_pkg::daisy_mode_t         daisy_mode_q;
  logic [EW-1:0]                   exp_p_dir_q, exp_n_dir_q;
  logic [EW-1:0]                   exp_p_out_q, exp_n_out_q;
  logic                            ack_q, err_q;
  logic [31:0]                     rdata_q;

  assign ofs    = req_i.addr[rp_bus_pkg::OFS_BITS-1:0];
  assign strobe = req_i.wen | req_i.ren;

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////

  always_comb begin
    rd_dat = '0;
    rd_hit = 1'b1;
    case (ofs)
      rp_bus_pkg::HK_ID:         rd_dat = rp_bus_pkg::HK_ID_VALUE;
      rp_bus_pkg::HK_DAISY_MODE: rd_dat = 32'(daisy_mode_q);
      rp_bus_pkg::HK_EXP_P_DIR:  rd_dat = 32'(exp_p_dir_q);
      rp_bus_pkg::HK_EXP_N_DIR:  rd_dat = 32'(exp_n_dir_q);
      rp_bus_pkg::HK_EXP_P_OUT:  rd_dat = 32'(exp_p_out_q);
      rp_bus_pkg::HK_EXP_N_OUT:  rd_dat = 32'(exp_n_out_q);
      rp_bus_pkg::HK_EXP_P_IN:   rd_dat = 32'(exp_p_in_i);  // live pins
      rp_bus_pkg::HK_EXP_N_IN:   rd_dat = 32'(exp_n_in_i);
      default:                   rd_hit = 1'b0;
    endcase
  end

  // config regs, writes to id/pin inputs fall through
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      daisy_mode_q <= '0;
      exp_p_dir_q  <= '0;
      exp_n_dir_q  <= '0;
      exp_p_out_q  <= '0;
      exp_n_out_q  <= '0;
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      ack_q <= strobe;
      err_q <= strobe & ~rd_hit;
      if (req_i.wen) begin
        case (ofs)
          rp_bus_pkg::HK_DAISY_MODE: daisy_mode_q <= rp_adc_pkg::daisy_mode_t'(req_i.wdata[DW-1:0]);
          rp_bus_pkg::HK_EXP_P_DIR:  exp_p_dir_q  <= req_i.wdata[EW-1:0];
          rp_bus_pkg::HK_EXP_N_DIR:  exp_n_dir_q  <= req_i.wdata[EW-1:0];
          rp_bus_pkg::HK_EXP_P_OUT:  exp_p_out_q  <= req_i.wdata[EW-1:0];
          rp_bus_pkg::HK_EXP_N_OUT:  exp_n_out_q  <= req_i.wdata[EW-1:0];
          default: ;
        endcase
      end
    end
  end

  // read data, zero on writes
  always_ff @(posedge adc_clk_01) begin
    if (strobe) rdata_q <= req_i.ren ? rd_dat : '0;
  end

  assign rsp_o        = '{rdata: rdata_q, ack: ack_q, err: err_q};
  assign daisy_mode_o = daisy_mode_q;
  assign exp_p_o      = '{dat: exp_p_out_q, oe: exp_p_dir_q};
  assign exp_n_o      = '{dat: exp_n_out_q, oe: exp_n_dir_q};

endmodule : hk_regs

//--- design/rp_adc_pkg.sv
////////////////////////////////////////
// ADC sample, slow DAC and expansion types
////////////////////////////////////////

package rp_adc_pkg;

  localparam int unsigned ADC_CHN  = 4;
  localparam int unsigned ADC_BITS = 14;
  localparam int unsigned PDM_BITS = 8;
  localparam int unsigned EXP_W    = 11;   // pins per side of the connector
  localparam int unsigned DAISY_W  = 16;   // daisy rx word

  // raw word, offset inverted (negative slope)
  typedef logic        [ADC_BITS-1:0] adc_raw_t;
  // two's complement sample
  typedef logic signed [ADC_BITS-1:0] adc_sample_t;

  // slow DAC level, range fixed at 255
  typedef logic [PDM_BITS-1:0] pdm_cfg_t;

  // one side of the expansion connector
  typedef struct packed {
    logic [EXP_W-1:0] dat;
    logic [EXP_W-1:0] oe;   // 1 = drive
  } exp_pins_t;

  // daisy mode register, bit 0 is sync_en
  typedef struct packed {
    logic trig_sel_asg;  // 1 generator trig, 0 scope trig
    logic trig_out_en;   // put trig on exp_n[0]
    logic sync_en;       // daisy link carries trigger
  } daisy_mode_t;

endpackage : rp_adc_pkg

//--- design/rp_bus_pkg.sv
////////////////////////////////////////
// system bus types and address map for the
// housekeeping and analog mixed signal regions
////////////////////////////////////////

package rp_bus_pkg;

  localparam int unsigned REGION_BITS = 3;   // addr[22:20]
  localparam int unsigned OFS_BITS    = 20;  // addr[19:0]
  localparam int unsigned REGION_NUM  = 8;

  localparam logic [31:0] HK_ID_VALUE = 32'h0AD4_0001;  // 4ch board, rev 1

  // bus request, wen/ren are single cycle strobes
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;
    logic        ren;
  } sys_req_t;

  // bus response, rdata/err qualified by ack
  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
    logic        err;
  } sys_rsp_t;

  typedef enum logic [REGION_BITS-1:0] {
    REG_HK      = 3'd0,
    REG_SCOPE01 = 3'd1,
    REG_SCOPE23 = 3'd2,
    REG_ASG     = 3'd3,
    REG_AMS     = 3'd4,
    REG_DAISY   = 3'd5,
    REG_FREE6   = 3'd6,
    REG_FREE7   = 3'd7
  } region_e;

  typedef enum logic [OFS_BITS-1:0] {
    HK_ID         = 20'h00,
    HK_DAISY_MODE = 20'h04,
    HK_EXP_P_DIR  = 20'h08,
    HK_EXP_N_DIR  = 20'h0C,
    HK_EXP_P_OUT  = 20'h10,
    HK_EXP_N_OUT  = 20'h14,
    HK_EXP_P_IN   = 20'h18,  // read only
    HK_EXP_N_IN   = 20'h1C   // read only
  } hk_ofs_e;

  typedef enum logic [OFS_BITS-1:0] {
    AMS_DAC_A = 20'h20,
    AMS_DAC_B = 20'h24,
    AMS_DAC_C = 20'h28,
    AMS_DAC_D = 20'h2C
  } ams_ofs_e;

endpackage : rp_bus_pkg

//--- design/rp_frontend_top.sv
////////////////////////////////////////
// 4ch ADC board frontend, adc_clk_01 domain
////////////////////////////////////////

`timescale 1ns/1ps

module rp_frontend_top (
  input  logic                                                adc_clk_01,
  input  logic                                                rst_n_i,
  // ADC
  input  rp_adc_pkg::adc_raw_t    [rp_adc_pkg::ADC_CHN-1:0]   adc_raw_i,
  output rp_adc_pkg::adc_sample_t [rp_adc_pkg::ADC_CHN-1:0]   adc_dat_o,
  // system bus
  input  rp_bus_pkg::sys_req_t                                sys_req_i,
  output rp_bus_pkg::sys_rsp_t                                sys_rsp_o,
  // expansion connector
  input  logic [rp_adc_pkg::EXP_W-1:0]                        exp_p_i,
  input  logic [rp_adc_pkg::EXP_W-1:0]                        exp_n_i,
  output rp_adc_pkg::exp_pins_t                               exp_p_o,
  output rp_adc_pkg::exp_pins_t                               exp_n_o,
  // triggers
  input  logic                                                scope_trig_i,
  input  logic                                                asg_trig_i,
  input  logic [rp_adc_pkg::DAISY_W-1:0]                      daisy_rx_dat_i,
  output logic                                                trig_ext_o,
  // slow DAC
  output logic [4-1:0]                                        dac_pdm_o
);

  rp_bus_pkg::sys_req_t    hk_req, ams_req;
  rp_bus_pkg::sys_rsp_t    hk_rsp, ams_rsp;
  rp_adc_pkg::daisy_mode_t daisy_mode;
  rp_adc_pkg::exp_pins_t   exp_n_reg;  // before trigger overlay

  ////////////////////////////////////////
  // ADC path
  ////////////////////////////////////////

  adc_sample_conv u_adc_conv (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i),
    .raw_i      (adc_raw_i),
    .sample_o   (adc_dat_o)
  );

  ////////////////////////////////////////
  // bus and register blocks
  ////////////////////////////////////////

  sys_bus_decoder u_bus_dec (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i),
    .req_i      (sys_req_i),
    .rsp_o      (sys_rsp_o),
    .hk_req_o   (hk_req),     // region 0
    .hk_rsp_i   (hk_rsp),
    .ams_req_o  (ams_req),    // region 4
    .ams_rsp_i  (ams_rsp)
  );

  hk_regs u_hk (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .req_i        (hk_req),
    .rsp_o        (hk_rsp),
    .exp_p_in_i   (exp_p_i),
    .exp_n_in_i   (exp_n_i),
    .daisy_mode_o (daisy_mode),
    .exp_p_o      (exp_p_o),    // p side goes straight out
    .exp_n_o      (exp_n_reg)
  );

  ams_pdm u_ams (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i),
    .req_i      (ams_req),
    .rsp_o      (ams_rsp),
    .dac_pdm_o  (dac_pdm_o)
  );

  exp_trig_route u_trig (
    .daisy_mode_i   (daisy_mode),
    .exp_n_reg_i    (exp_n_reg),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .exp_p_in0_i    (exp_p_i[0]),  // ext trigger pin
    .exp_n_o        (exp_n_o),
    .trig_ext_o     (trig_ext_o)
  );

endmodule : rp_frontend_top

//--- design/sys_bus_decoder.sv
////////////////////////////////////////
// system bus region decoder, 8 regions
// unmapped regions answer with err
////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic                 adc_clk_01,
  input  logic                 rst_n_i,
  input  rp_bus_pkg::sys_req_t req_i,
  output rp_bus_pkg::sys_rsp_t rsp_o,
  output rp_bus_pkg::sys_req_t hk_req_o,
  input  rp_bus_pkg::sys_rsp_t hk_rsp_i,
  output rp_bus_pkg::sys_req_t ams_req_o,
  input  rp_bus_pkg::sys_rsp_t ams_rsp_i
);

  rp_bus_pkg::region_e                 region;
  rp_bus_pkg::region_e                 region_q;   // region of last strobe
  logic [rp_bus_pkg::REGION_NUM-1:0]   reg_hit;    // one hot
  logic                                strobe;
  logic                                unm_ack_q;  // err ack for empty regions

  assign strobe  = req_i.wen | req_i.ren;
  assign region  = rp_bus_pkg::region_e'(req_i.addr[rp_bus_pkg::OFS_BITS +: rp_bus_pkg::REGION_BITS]);
  assign reg_hit = rp_bus_pkg::REGION_NUM'(1) << region;

  // request fan out, strobes only to the addressed region
  always_comb begin
    hk_req_o      = req_i;
    hk_req_o.wen  = req_i.wen & reg_hit[rp_bus_pkg::REG_HK];
    hk_req_o.ren  = req_i.ren & reg_hit[rp_bus_pkg::REG_HK];
    ams_req_o     = req_i;
    ams_req_o.wen = req_i.wen & reg_hit[rp_bus_pkg::REG_AMS];
    ams_req_o.ren = req_i.ren & reg_hit[rp_bus_pkg::REG_AMS];
  end

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      region_q  <= rp_bus_pkg::REG_HK;
      unm_ack_q <= 1'b0;
    end else begin
      if (strobe) region_q <= region;
      unm_ack_q <= strobe & ~reg_hit[rp_bus_pkg::REG_HK] & ~reg_hit[rp_bus_pkg::REG_AMS];
    end
  end

  ////////////////////////////////////////
  // response mux, one cycle behind request
  ////////////////////////////////////////

  always_comb begin
    case (region_q)
      rp_bus_pkg::REG_HK:  rsp_o = hk_rsp_i;
      rp_bus_pkg::REG_AMS: rsp_o = ams_rsp_i;
      default: begin
        rsp_o.rdata = '0;
        rsp_o.ack   = unm_ack_q;
        rsp_o.err   = unm_ack_q;
      end
    endcase
  end

  // master never issues read and write together
  a_no_rw: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    !(req_i.wen && req_i.ren));

  // exactly one ack, one cycle after each strobe, whichever region answers
  a_ack_lat: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    rsp_o.ack == $past(strobe));

endmodule : sys_bus_decoder

//--- dv/rp_frontend_cases.txt
# W addr wdata err | R addr rdata err | A raw0 raw1 raw2 raw3 | N count | P channel cfg
# T mode scope asg daisy p0 exp_n0_dat exp_n0_oe trig_ext    (all fields hex)
R 00000000 0AD40001 0
W 00000000 12345678 0
R 00000000 0AD40001 0
W 00000004 00000005 0
R 00000004 00000005 0
W 00000008 000007FF 0
R 00000008 000007FF 0
R 00000018 000005A5 0
W 00000018 00000000 0
R 00000018 000005A5 0
W 00400024 000000C3 0
R 00400024 000000C3 0
W 00100004 00000000 1
W 00400004 00000000 1
R 00000004 00000005 0
W 00000024 00000011 1
R 00400024 000000C3 0
R 00700000 00000000 1
W 00000040 FFFFFFFF 1
R 00400030 00000000 1
A 0000 1FFF 2000 3FFF
A 1234 0ABC 2F0F 3001
N 40
P 0 00
P 1 01
P 2 80
P 3 FF
T 0 1 0 0000 1 0 0 1
T 2 1 0 0000 1 1 1 1
T 2 0 1 0000 1 0 1 1
T 6 0 1 0000 0 1 1 0
T 6 1 0 0000 1 0 1 1
T 4 1 1 0000 1 0 0 1
T 1 0 0 0010 1 0 0 0
T 1 0 0 0000 1 0 0 1
T 7 0 1 0001 1 1 1 0

//--- dv/tb_rp_frontend.sv
////////////////////////////////////////
// frontend testbench, bus, ADC, PDM and trigger
// cases come from dv/rp_frontend_cases.txt
////////////////////////////////////////

`timescale 1ns/1ps

module tb_rp_frontend;

  localparam int unsigned NCH         = rp_adc_pkg::ADC_CHN;
  localparam int unsigned ACK_TIMEOUT = 20;  // cycles
  localparam logic [31:0] DAISY_ADDR  = {12'h0, rp_bus_pkg::HK_DAISY_MODE};
  localparam logic [31:0] DAC0_ADDR   = {9'h0, rp_bus_pkg::REG_AMS, rp_bus_pkg::AMS_DAC_A};

  logic                              adc_clk_01;
  logic                              rst_n_i;
  rp_adc_pkg::adc_raw_t    [NCH-1:0] adc_raw;
  rp_adc_pkg::adc_sample_t [NCH-1:0] adc_dat;
  rp_bus_pkg::sys_req_t              sys_req;
  rp_bus_pkg::sys_rsp_t              sys_rsp;
  logic [rp_adc_pkg::EXP_W-1:0]      exp_p_in, exp_n_in;
  rp_adc_pkg::exp_pins_t             exp_p_out, exp_n_out;
  logic                              scope_trig, asg_trig, trig_ext;
  logic [rp_adc_pkg::DAISY_W-1:0]    daisy_rx;
  logic [3:0]                        dac_pdm;
  int                                errors;
  int                                checks;

  rp_frontend_top dut0 (
    .adc_clk_01 (adc_clk_01),     .rst_n_i        (rst_n_i),
    .adc_raw_i  (adc_raw),        .adc_dat_o      (adc_dat),
    .sys_req_i  (sys_req),        .sys_rsp_o      (sys_rsp),
    .exp_p_i    (exp_p_in),       .exp_n_i        (exp_n_in),
    .exp_p_o    (exp_p_out),      .exp_n_o        (exp_n_out),
    .scope_trig_i (scope_trig),   .asg_trig_i     (asg_trig),
    .daisy_rx_dat_i (daisy_rx),   .trig_ext_o     (trig_ext),
    .dac_pdm_o  (dac_pdm)
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #5 adc_clk_01 = ~adc_clk_01;  // 100 MHz
  end

  // drive point, 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge adc_clk_01);
    #1;
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input rp_bus_pkg::sys_rsp_t got, input rp_bus_pkg::sys_rsp_t want,
                           input bit with_data, input string what);
    checks++;
    if (got.ack !== want.ack || got.err !== want.err || (with_data && got.rdata !== want.rdata)) begin
      errors++;
      $display("FAIL at %t: %s, ack/err/rdata %b/%b/%h, expected %b/%b/%h", $time, what,
               got.ack, got.err, got.rdata, want.ack, want.err, want.rdata);
    end
  endtask

  task automatic check_sample(input rp_adc_pkg::adc_sample_t got,
                              input rp_adc_pkg::adc_sample_t want, input int ch);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL at %t: adc ch%0d sample %h, expected %h", $time, ch, got, want);
    end
  endtask

  task automatic check_exp(input rp_adc_pkg::exp_pins_t got, input rp_adc_pkg::exp_pins_t want,
                           input rp_adc_pkg::exp_pins_t mask, input string what);
    checks++;
    if (((got ^ want) & mask) !== '0) begin
      errors++;
      $display("FAIL at %t: %s dat/oe %h/%h, expected %h/%h", $time, what,
               got.dat & mask.dat, got.oe & mask.oe, want.dat, want.oe);
    end
  endtask

  task automatic check_bit(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL at %t: %s, got %b expected %b", $time, what, got, want);
    end
  endtask

  // msb kept, lower 13 bits flipped
  function automatic rp_adc_pkg::adc_sample_t expected_sample(input rp_adc_pkg::adc_raw_t raw);
    return rp_adc_pkg::adc_sample_t'(raw ^ 14'h1FFF);
  endfunction

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata, input bit wr,
                            output rp_bus_pkg::sys_rsp_t rsp);
    int cycles;
    sys_req = '{addr: addr, wdata: wdata, wen: wr, ren: !wr};
    next_cycle();
    sys_req.wen = 1'b0;  // single cycle strobe
    sys_req.ren = 1'b0;
    cycles = 1;
    while (sys_rsp.ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    rsp = sys_rsp;
    if (sys_rsp.ack !== 1'b1) begin
      errors++;
      $display("timeout: no bus ack for addr %h within %0d cycles", addr, ACK_TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end else if (cycles != 1) begin
      errors++;
      $display("FAIL at %t: ack %0d cycles after strobe, addr %h", $time, cycles, addr);
    end
  endtask

  task automatic adc_random(input int count);
    logic [NCH*rp_adc_pkg::ADC_BITS-1:0] sent_q[$];  // words in flight
    rp_adc_pkg::adc_raw_t [NCH-1:0]      old;
    for (int k = 0; k <= count; k++) begin
      if (k < count) begin
        for (int ch = 0; ch < NCH; ch++) adc_raw[ch] = 14'($urandom());
      end
      sent_q.push_back(adc_raw);
      next_cycle();
      if (sent_q.size() >= 2) begin
        old = sent_q.pop_front();  // driven two edges back
        for (int ch = 0; ch < NCH; ch++) check_sample(adc_dat[ch], expected_sample(old[ch]), ch);
      end
    end
  endtask

  task automatic pdm_density(input int ch, input logic [7:0] cfg);
    rp_bus_pkg::sys_rsp_t rsp;
    int                   ones;
    bus_access(DAC0_ADDR + 32'(4 * ch), {24'h0, cfg}, 1'b1, rsp);
    check_rsp(rsp, '{rdata: '0, ack: 1'b1, err: 1'b0}, 1'b0, "pdm cfg write");
    next_cycle();  // new cfg in the accumulator
    next_cycle();
    ones = 0;
    repeat (256) begin
      ones += int'(dac_pdm[ch]);
      next_cycle();
    end
    check_bit(ones == int'(cfg), 1'b1,
              $sformatf("pdm ch%0d %0d ones over 256 cycles, cfg %0d", ch, ones, cfg));
  endtask

  task automatic trig_route(input logic [31:0] mode, input logic scope, input logic asg,
                            input logic [15:0] daisy, input logic p0, input logic n0_dat,
                            input logic n0_oe, input logic ext);
    rp_bus_pkg::sys_rsp_t  rsp;
    rp_adc_pkg::exp_pins_t want, mask;
    bus_access(DAISY_ADDR, mode, 1'b1, rsp);
    check_rsp(rsp, '{rdata: '0, ack: 1'b1, err: 1'b0}, 1'b0, "daisy mode write");
    scope_trig  = scope;
    asg_trig    = asg;
    daisy_rx    = daisy;
    exp_p_in[0] = p0;
    next_cycle();
    want = '0;
    mask = '0;
    want.dat[0] = n0_dat;
    want.oe[0]  = n0_oe;
    mask.dat[0] = 1'b1;
    mask.oe[0]  = 1'b1;
    check_exp(exp_n_out, want, mask, $sformatf("exp_n pin 0, mode %0h", mode));
    check_bit(trig_ext, ext, $sformatf("trig_ext_o, mode %0h daisy %h", mode, daisy));
  endtask

  // expansion regs straight onto the pins, trigger overlay off
  task automatic exp_reg_outputs(input logic [10:0] p_dat, input logic [10:0] p_oe,
                                 input logic [10:0] n_dat, input logic [10:0] n_oe);
    rp_bus_pkg::sys_rsp_t  rsp;
    rp_adc_pkg::exp_pins_t want_p, want_n;
    want_p = '{dat: p_dat, oe: p_oe};
    want_n = '{dat: n_dat, oe: n_oe};
    bus_access(DAISY_ADDR, '0, 1'b1, rsp);
    check_rsp(rsp, '{rdata: '0, ack: 1'b1, err: 1'b0}, 1'b0, "daisy mode clear");
    bus_access({12'h0, rp_bus_pkg::HK_EXP_P_DIR}, 32'(p_oe), 1'b1, rsp);
    bus_access({12'h0, rp_bus_pkg::HK_EXP_N_DIR}, 32'(n_oe), 1'b1, rsp);
    bus_access({12'h0, rp_bus_pkg::HK_EXP_P_OUT}, 32'(p_dat), 1'b1, rsp);
    bus_access({12'h0, rp_bus_pkg::HK_EXP_N_OUT}, 32'(n_dat), 1'b1, rsp);
    // one cycle after the last strobe
    check_exp(exp_p_out, want_p, '1, "exp_p after register writes");
    check_exp(exp_n_out, want_n, '1, "exp_n after register writes");
    bus_access({12'h0, rp_bus_pkg::HK_EXP_N_IN}, '0, 1'b0, rsp);
    check_rsp(rsp, '{rdata: 32'(exp_n_in), ack: 1'b1, err: 1'b0}, 1'b1, "read exp_n pins");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int                    fd, rc;
    logic [7:0]            kind;
    logic [8*200-1:0]      line_buf;
    logic [31:0]           v0, v1, v2, v3, v4, v5, v6, v7;
    rp_bus_pkg::sys_rsp_t  rsp;
    $timeformat(-9, 0, " ns", 0);
    errors     = 0;
    checks     = 0;
    rst_n_i    = 1'b0;
    sys_req    = '0;
    adc_raw    = '0;
    exp_p_in   = 11'h5A5;  // pattern read back through HK_EXP_P_IN
    exp_n_in   = 11'h2B6;
    scope_trig = 1'b0;
    asg_trig   = 1'b0;
    daisy_rx   = '0;
    void'($urandom(1138));
    repeat (16) @(posedge adc_clk_01);
    #1 rst_n_i = 1'b1;
    next_cycle();
    // reset state
    check_rsp(sys_rsp, '0, 1'b0, "response after reset");
    check_exp(exp_n_out, '0, '1, "exp_n after reset");
    check_exp(exp_p_out, '0, '1, "exp_p after reset");
    check_bit(dac_pdm == 4'h0, 1'b1, "pdm outputs low after reset");
    for (int ch = 0; ch < NCH; ch++) check_sample(adc_dat[ch], '0, ch);
    fd = $fopen("dv/rp_frontend_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open case file dv/rp_frontend_cases.txt");
    end else begin
      rc = $fscanf(fd, " %c", kind);
      while (rc == 1) begin
        case (kind)
          "#": rc = $fgets(line_buf, fd);  // column notes
          "W": begin
            rc = $fscanf(fd, "%h %h %h", v0, v1, v2);
            bus_access(v0, v1, 1'b1, rsp);
            check_rsp(rsp, '{rdata: '0, ack: 1'b1, err: v2[0]}, 1'b0,
                      $sformatf("write %h", v0));
          end
          "R": begin
            rc = $fscanf(fd, "%h %h %h", v0, v1, v2);
            bus_access(v0, '0, 1'b0, rsp);
            check_rsp(rsp, '{rdata: v1, ack: 1'b1, err: v2[0]}, 1'b1,
                      $sformatf("read %h", v0));
          end
          "A": begin
            rc = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
            adc_raw = {v3[13:0], v2[13:0], v1[13:0], v0[13:0]};
            next_cycle();
            adc_raw = ~adc_raw;  // word held for one cycle only
            next_cycle();
            check_sample(adc_dat[0], expected_sample(v0[13:0]), 0);
            check_sample(adc_dat[1], expected_sample(v1[13:0]), 1);
            check_sample(adc_dat[2], expected_sample(v2[13:0]), 2);
            check_sample(adc_dat[3], expected_sample(v3[13:0]), 3);
          end
          "N": begin
            rc = $fscanf(fd, "%h", v0);
            adc_random(int'(v0));
          end
          "P": begin
            rc = $fscanf(fd, "%h %h", v0, v1);
            pdm_density(int'(v0), v1[7:0]);
          end
          "T": begin
            rc = $fscanf(fd, "%h %h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6, v7);
            trig_route(v0, v1[0], v2[0], v3[15:0], v4[0], v5[0], v6[0], v7[0]);
          end
          default: begin
            errors++;
            $display("unknown case kind '%c' in case file", kind);
            rc = $fgets(line_buf, fd);
          end
        endcase
        rc = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
    end
    exp_reg_outputs(11'h3C5, 11'h5AA, 11'h1F1, 11'h60E);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_rp_frontend

//--- run.sh
#!/bin/sh
# build and run the frontend testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rp_frontend || exit 1
out="$(./obj_dir/Vtb_rp_frontend)"
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1
